//--- axi_burst_pkg.sv
`include "vldst_defines.svh"

package axi_burst_pkg;

  ////////////////////
  // Address word
  ////////////////////

  // Page number plus offset inside the page
  typedef struct packed {
    logic [`ADDR_WIDTH-`PAGE_BITS-1:0] page;
    logic [`PAGE_BITS-1:0]             offset;
  } page_addr_t;

  // Same bus address, seen flat or split at the page boundary
  typedef union packed {
    logic [`ADDR_WIDTH-1:0] flat;
    page_addr_t             pg;
  } axi_addr_u;

  ////////////////////
  // LSU command
  ////////////////////

  // Mirror of one issued AR/AW beat for the load/store units
  typedef struct packed {
    axi_addr_u                  addr;
    // Beats in the burst minus one
    logic [`AXI_LEN_WIDTH-1:0]  len;
    // log2 of bytes per beat
    logic [`AXI_SIZE_WIDTH-1:0] size;
    logic                       is_load;
  } lsu_cmd_t;

endpackage

//--- burst_engine.sv
`include "vldst_defines.svh"

module burst_engine (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Request buffer read side
  input  logic                         req_empty_i,
  input  vreq_pkg::vreq_t              req_data_i,
  output logic                         req_pop_o,
  // AR channel
  output axi_burst_pkg::axi_addr_u     ar_addr_o,
  output logic [`AXI_LEN_WIDTH-1:0]    ar_len_o,
  output logic [`AXI_SIZE_WIDTH-1:0]   ar_size_o,
  output logic                         ar_valid_o,
  input  logic                         ar_ready_i,
  // AW channel
  output axi_burst_pkg::axi_addr_u     aw_addr_o,
  output logic [`AXI_LEN_WIDTH-1:0]    aw_len_o,
  output logic [`AXI_SIZE_WIDTH-1:0]   aw_size_o,
  output logic                         aw_valid_o,
  input  logic                         aw_ready_i,
  // Command queue write side plus its head kind
  input  logic                         cmd_full_i,
  input  logic                         cmd_empty_i,
  input  logic                         cmd_head_is_load_i,
  output logic                         cmd_push_o,
  output axi_burst_pkg::lsu_cmd_t      cmd_data_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PLAN,
    ST_ISSUE
  } state_e;

  state_e                     state_q, state_d;

  // Request in progress
  logic                       is_load_q;
  logic                       is_strided_q;
  vreq_pkg::vew_e             vew_q;
  logic [`ADDR_WIDTH-1:0]     stride_q;
  logic [`VL_WIDTH-1:0]       rem_q;
  axi_burst_pkg::axi_addr_u   cur_addr_q;

  // Burst currently on offer
  axi_burst_pkg::axi_addr_u   end_q;
  axi_burst_pkg::axi_addr_u   next_start_q;
  logic [`AXI_LEN_WIDTH-1:0]  len_q;

  // Planner inputs and results
  axi_burst_pkg::axi_addr_u   plan_addr;
  logic [`VL_WIDTH-1:0]       plan_rem;
  axi_burst_pkg::axi_addr_u   plan_aligned;
  axi_burst_pkg::axi_addr_u   plan_end;
  axi_burst_pkg::axi_addr_u   plan_next;
  logic [`ADDR_WIDTH:0]       plan_last_byte;
  logic [`ADDR_WIDTH:0]       plan_burst_lim;
  logic [`ADDR_WIDTH:0]       plan_page_end;
  logic [`ADDR_WIDTH:0]       plan_end_w;
  logic [`ADDR_WIDTH-1:0]     plan_span;
  logic [`AXI_LEN_WIDTH-1:0]  plan_len;

  // Beat handshake
  logic                       order_ok;
  logic                       beat_valid;
  logic                       beat_ready;
  logic                       fire;
  logic [`AXI_LEN_WIDTH-1:0]  beat_len;
  logic [`AXI_SIZE_WIDTH-1:0] beat_size;
  logic [`ADDR_WIDTH-1:0]     consumed;
  logic [`VL_WIDTH-1:0]       rem_after;

  ////////////////////
  // Burst planner
  ////////////////////

  // First burst plans from the popped request, later ones from the
  // burst being transferred, so back-to-back beats need no bubble
  assign plan_addr = (state_q == ST_PLAN) ? cur_addr_q : next_start_q;
  assign plan_rem  = (state_q == ST_PLAN) ? rem_q : rem_after;

  always_comb begin
    plan_aligned.flat = plan_addr.flat & ~((`ADDR_WIDTH'(1) << `BUS_BYTES_LOG) - 1'b1);
    // Candidate ends, one bit wider so nothing wraps at the top of memory
    plan_last_byte = {1'b0, plan_addr.flat}
                   + ((`ADDR_WIDTH+1)'(plan_rem) << vew_q) - 1'b1;
    plan_burst_lim = {1'b0, plan_aligned.flat}
                   + ((`ADDR_WIDTH+1)'(`MAX_BURST_BEATS) << `BUS_BYTES_LOG) - 1'b1;
    // Last byte of the page holding the start address
    plan_page_end  = {1'b0, plan_addr.pg.page, {`PAGE_BITS{1'b1}}};
    // Smallest of the three
    plan_end_w = plan_last_byte;
    if (plan_burst_lim < plan_end_w) plan_end_w = plan_burst_lim;
    if (plan_page_end < plan_end_w) plan_end_w = plan_page_end;
    plan_end.flat  = plan_end_w[`ADDR_WIDTH-1:0];
    plan_next.flat = plan_end.flat + 1'b1;
    // Bus words from aligned start to end, minus one
    plan_span = plan_end.flat - plan_aligned.flat;
    plan_len  = plan_span[`BUS_BYTES_LOG +: `AXI_LEN_WIDTH];
  end

  ////////////////////
  // Element count
  ////////////////////

  // Elements covered by the burst on offer
  assign consumed = (end_q.flat - cur_addr_q.flat + 1'b1) >> vew_q;

  always_comb begin
    if (is_strided_q) begin
      rem_after = rem_q - 1'b1;
    end else if (`ADDR_WIDTH'(rem_q) > consumed) begin
      rem_after = rem_q - consumed[`VL_WIDTH-1:0];
    end else begin
      // Saturate, the tail burst may cover padding bytes
      rem_after = '0;
    end
  end

  ////////////////////
  // Beat issue
  ////////////////////

  // No channel switch while commands of the other kind are queued
  assign order_ok   = cmd_empty_i || (cmd_head_is_load_i == is_load_q);
  // Once raised this stays high, only this engine pushes the queue
  assign beat_valid = (state_q == ST_ISSUE) && order_ok && !cmd_full_i;
  assign beat_ready = is_load_q ? ar_ready_i : aw_ready_i;
  assign fire       = beat_valid && beat_ready;

  // Strided beats are single elements, unit-stride beats use the full bus
  assign beat_len  = is_strided_q ? '0 : len_q;
  assign beat_size = is_strided_q ? `AXI_SIZE_WIDTH'(vew_q)
                                  : `AXI_SIZE_WIDTH'(`BUS_BYTES_LOG);

  assign ar_valid_o = beat_valid && is_load_q;
  assign ar_addr_o  = cur_addr_q;
  assign ar_len_o   = beat_len;
  assign ar_size_o  = beat_size;
  assign aw_valid_o = beat_valid && !is_load_q;
  assign aw_addr_o  = cur_addr_q;
  assign aw_len_o   = beat_len;
  assign aw_size_o  = beat_size;

  // Mirror each transfer into the command queue in the same cycle
  assign cmd_push_o = fire;
  assign cmd_data_o = '{addr: cur_addr_q, len: beat_len, size: beat_size, is_load: is_load_q};

  // Take a new request only when idle
  assign req_pop_o = (state_q == ST_IDLE) && !req_empty_i;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (!req_empty_i) state_d = ST_PLAN;
      end
      ST_PLAN: begin
        state_d = ST_ISSUE;
      end
      ST_ISSUE: begin
        if (fire && (rem_after == '0)) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      rem_q   <= '0;
    end else begin
      state_q <= state_d;
      if (req_pop_o) rem_q <= req_data_i.vl;
      else if (fire) rem_q <= rem_after;
    end
  end

  // Request fields and burst plan
  always_ff @(posedge clk_i) begin
    if (req_pop_o) begin
      cur_addr_q.flat <= req_data_i.addr;
      stride_q        <= req_data_i.stride;
      vew_q           <= req_data_i.vew;
      is_load_q       <= vreq_pkg::is_load(req_data_i.op);
      is_strided_q    <= vreq_pkg::is_strided(req_data_i.op);
    end else if (fire) begin
      if (is_strided_q) cur_addr_q.flat <= cur_addr_q.flat + stride_q;
      else cur_addr_q <= next_start_q;
    end
    // Plan loads once after the pop and again on every transfer
    if ((state_q == ST_PLAN) || fire) begin
      end_q        <= plan_end;
      next_start_q <= plan_next;
      len_q        <= plan_len;
    end
  end

endmodule

//--- sync_fifo.sv
module sync_fifo #(
  parameter int unsigned depth = 2,
  parameter int unsigned width = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [width-1:0] data_i,
  input  logic             pop_i,
  output logic [width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_width = $clog2(depth + 1);

  // Storage and pointers
  logic [width-1:0]     mem_q [depth];
  logic [ptr_width-1:0] rd_ptr_q, wr_ptr_q;
  logic [cnt_width-1:0] count_q;
  logic                 do_push, do_pop;

  // Pointer step with wrap at the last slot, depth need not be a power of two
  function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == cnt_width'(depth));
  assign empty_o = (count_q == '0);

  // Push into a full buffer and pop from an empty one are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head word, valid whenever not empty
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      // Occupancy only moves when exactly one side acts
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  // Data slots
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- tb_vaddrgen_top.sv
`include "vldst_defines.svh"

module tb_vaddrgen_top;
  timeunit 1ns;
  timeprecision 100ps;

  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  vreq_pkg::vmem_op_e           req_op_i;
  logic [`ADDR_WIDTH-1:0]       req_addr_i;
  logic [`VL_WIDTH-1:0]         req_vl_i;
  logic [`ADDR_WIDTH-1:0]       req_stride_i;
  vreq_pkg::vew_e               req_vew_i;
  logic                         req_valid_i;
  logic                         req_ack_o, req_error_o;
  axi_burst_pkg::axi_addr_u     ar_addr_o, aw_addr_o;
  logic [`AXI_LEN_WIDTH-1:0]    ar_len_o, aw_len_o;
  logic [`AXI_SIZE_WIDTH-1:0]   ar_size_o, aw_size_o;
  logic                         ar_valid_o, aw_valid_o;
  logic                         ar_ready_i = 1'b0;
  logic                         aw_ready_i = 1'b0;
  axi_burst_pkg::lsu_cmd_t      cmd_o;
  logic                         cmd_valid_o;
  logic                         cmd_pop_i = 1'b0;

  // Reference queues, beats still to come and commands still in the DUT queue
  axi_burst_pkg::lsu_cmd_t      exp_beat_q[$];
  axi_burst_pkg::lsu_cmd_t      exp_cmd_q[$];
  axi_burst_pkg::lsu_cmd_t      beat_head, cmd_head, ar_word, aw_word;
  logic                         beat_avail = 1'b0;
  logic                         cmd_avail = 1'b0;
  logic [15:0]                  lfsr_q = 16'd57;
  logic                         hold_pop = 1'b0;
  logic                         quiet_window = 1'b0;
  string                        cur_test = "none";
  int                           err_cnt = 0;
  int                           test_err_start = 0;
  int                           pass_cnt = 0;
  int                           fail_cnt = 0;
  int                           total_beats = 0;
  int                           cycle_cnt = 0;

  vaddrgen_top uut (.*);

  always #20 clk_i = ~clk_i;

  // Beats as seen on each channel, in command form
  assign ar_word = '{addr: ar_addr_o, len: ar_len_o, size: ar_size_o, is_load: 1'b1};
  assign aw_word = '{addr: aw_addr_o, len: aw_len_o, size: aw_size_o, is_load: 1'b0};

  ////////////////////
  // Helpers
  ////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic void refresh_heads();
    beat_avail = (exp_beat_q.size() != 0);
    beat_head  = beat_avail ? exp_beat_q[0] : '0;
    cmd_avail  = (exp_cmd_q.size() != 0);
    cmd_head   = cmd_avail ? exp_cmd_q[0] : '0;
  endfunction

  task automatic value_error(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
    err_cnt++;
  endtask

  task automatic report_failure(input string what);
    $display("test %s: %s", cur_test, what);
    err_cnt++;
  endtask

  // Model of one request, returns the expected error flag
  function automatic logic expect_request(input vreq_pkg::vmem_op_e op,
      input logic [31:0] addr, input logic [15:0] vl, input logic [31:0] stride,
      input vreq_pkg::vew_e vew);
    longint unsigned a, aligned, fin, lim, pg_end, used, rem;
    logic [31:0] sa;
    axi_burst_pkg::lsu_cmd_t beat;
    if ((addr & ((32'd1 << vew) - 1)) != 0) return 1'b1;
    beat.is_load = (op == vreq_pkg::VOP_LOAD_UNIT) || (op == vreq_pkg::VOP_LOAD_STRIDE);
    if ((op == vreq_pkg::VOP_LOAD_STRIDE) || (op == vreq_pkg::VOP_STORE_STRIDE)) begin
      // One element per beat, address steps by the stride
      sa = addr;
      repeat (vl) begin
        beat.addr.flat = sa;
        beat.len       = '0;
        beat.size      = vew;
        exp_beat_q.push_back(beat);
        total_beats++;
        sa = sa + stride;
      end
    end else begin
      rem = vl;
      a   = addr;
      while (rem > 0) begin
        aligned = a & ~((64'd1 << `BUS_BYTES_LOG) - 1);
        // End is the nearest of transfer end, burst limit and page end
        fin     = a + (rem << vew) - 1;
        lim     = aligned + (64'(`MAX_BURST_BEATS) << `BUS_BYTES_LOG) - 1;
        pg_end  = a | ((64'd1 << `PAGE_BITS) - 1);
        if (lim < fin) fin = lim;
        if (pg_end < fin) fin = pg_end;
        beat.addr.flat = a[31:0];
        beat.len       = 8'((fin - aligned) >> `BUS_BYTES_LOG);
        beat.size      = `BUS_BYTES_LOG;
        exp_beat_q.push_back(beat);
        total_beats++;
        used = (fin - a + 1) >> vew;
        rem  = (rem > used) ? rem - used : 0;
        a    = fin + 1;
      end
    end
    refresh_heads();
    return 1'b0;
  endfunction

  // Level valid held until the ack pulse, sampled mid-cycle
  task automatic send_request(input vreq_pkg::vmem_op_e op, input logic [31:0] addr,
      input logic [15:0] vl, input logic [31:0] stride, input vreq_pkg::vew_e vew);
    logic exp_err;
    logic got_err;
    @(posedge clk_i);
    #2;
    quiet_window = 1'b0;
    exp_err      = expect_request(op, addr, vl, stride, vew);
    req_op_i     = op;
    req_addr_i   = addr;
    req_vl_i     = vl;
    req_stride_i = stride;
    req_vew_i    = vew;
    req_valid_i  = 1'b1;
    do @(negedge clk_i); while (!req_ack_o);
    got_err = req_error_o;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    chk_error: assert (got_err == exp_err)
      else value_error("request error flag", 64'(exp_err), 64'(got_err));
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == test_err_start) begin
      pass_cnt++;
      $display("test %s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", cur_test, err_cnt - test_err_start);
    end
  endtask

  // Every expected beat issued and every command taken
  task automatic wait_drain();
    while ((exp_beat_q.size() != 0) || (exp_cmd_q.size() != 0)) @(posedge clk_i);
  endtask

  ////////////////////
  // Random ready and pop
  ////////////////////

  always @(posedge clk_i) begin
    #2;
    lfsr_q     = lfsr_next(lfsr_q);
    ar_ready_i = lfsr_q[0];
    lfsr_q     = lfsr_next(lfsr_q);
    aw_ready_i = lfsr_q[0];
    lfsr_q     = lfsr_next(lfsr_q);
    cmd_pop_i  = lfsr_q[0] && !hold_pop;
  end

  // Move transferred beats into the expected command queue
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (cmd_valid_o && cmd_pop_i && cmd_avail) void'(exp_cmd_q.pop_front());
      if ((ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i)) begin
        if (beat_avail) exp_cmd_q.push_back(exp_beat_q.pop_front());
      end
      refresh_heads();
    end
  end

  // Limit grows with the beats the model expects
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > total_beats * 8 + 200) begin
      $display("timeout, run stopped after %0d cycles with beats still missing", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_quiet: assert property (@(posedge clk_i) quiet_window |->
      !req_ack_o && !req_error_o && !ar_valid_o && !aw_valid_o && !cmd_valid_o)
    else report_failure("an output was high after reset before any request");
  a_err_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_error_o |-> req_ack_o)
    else report_failure("error pulse came without acknowledge");
  a_ar_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o && ar_ready_i |-> beat_avail)
    else report_failure("AR transfer while no beat was expected");
  a_aw_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_valid_o && aw_ready_i |-> beat_avail)
    else report_failure("AW transfer while no beat was expected");
  a_ar_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o && ar_ready_i && beat_avail |-> ar_word == beat_head)
    else value_error("AR beat", 64'($sampled(beat_head)), 64'($sampled(ar_word)));
  a_aw_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_valid_o && aw_ready_i && beat_avail |-> aw_word == beat_head)
    else value_error("AW beat", 64'($sampled(beat_head)), 64'($sampled(aw_word)));
  // Held beats keep valid and fields
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_word))
    else report_failure("AR valid dropped or fields moved while ready was low");
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_word))
    else report_failure("AW valid dropped or fields moved while ready was low");
  a_cmd_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_valid_o && cmd_pop_i |-> cmd_avail)
    else report_failure("command offered that matches no transfer");
  a_cmd_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_valid_o && cmd_pop_i && cmd_avail |-> cmd_o == cmd_head)
    else value_error("command", 64'($sampled(cmd_head)), 64'($sampled(cmd_o)));
  // No beat on one channel while the queue holds the other kind
  a_aw_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_valid_o |-> !(cmd_valid_o && cmd_o.is_load))
    else report_failure("AW beat offered while a load command was queued");
  a_ar_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o |-> !(cmd_valid_o && !cmd_o.is_load))
    else report_failure("AR beat offered while a store command was queued");

  ////////////////////
  // Tests
  ////////////////////

  initial begin
    rst_ni       = 1'b0;
    req_op_i     = vreq_pkg::VOP_LOAD_UNIT;
    req_addr_i   = '0;
    req_vl_i     = '0;
    req_stride_i = '0;
    req_vew_i    = vreq_pkg::VEW_8;
    req_valid_i  = 1'b0;

    begin_test("reset");
    @(posedge clk_i);
    quiet_window = 1'b1;
    repeat (9) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (5) @(posedge clk_i);
    end_test();

    begin_test("misaligned base");
    send_request(vreq_pkg::VOP_LOAD_UNIT, 32'h0000_1002, 16'd4, 32'd0, vreq_pkg::VEW_32);
    send_request(vreq_pkg::VOP_STORE_STRIDE, 32'h0000_2001, 16'd3, 32'd8, vreq_pkg::VEW_16);
    // Zero length is fine and moves nothing
    send_request(vreq_pkg::VOP_LOAD_UNIT, 32'h0000_3000, 16'd0, 32'd0, vreq_pkg::VEW_64);
    repeat (10) @(posedge clk_i);
    wait_drain();
    end_test();

    begin_test("unit-stride splitting");
    // Crosses pages and runs past 256 beats
    send_request(vreq_pkg::VOP_LOAD_UNIT, 32'h0000_0f40, 16'd600, 32'd0, vreq_pkg::VEW_64);
    send_request(vreq_pkg::VOP_LOAD_UNIT, 32'h0000_7ffa, 16'd10, 32'd0, vreq_pkg::VEW_16);
    wait_drain();
    end_test();

    begin_test("strided store");
    send_request(vreq_pkg::VOP_STORE_STRIDE, 32'h4000_0100, 16'd7, 32'h24,
                 vreq_pkg::VEW_32);
    // Negative stride wraps downward
    send_request(vreq_pkg::VOP_STORE_STRIDE, 32'h0000_0100, 16'd3, 32'hffff_fff0,
                 vreq_pkg::VEW_64);
    wait_drain();
    end_test();

    begin_test("back-pressure");
    send_request(vreq_pkg::VOP_STORE_UNIT, 32'h0000_2ff4, 16'd40, 32'd0, vreq_pkg::VEW_32);
    send_request(vreq_pkg::VOP_LOAD_STRIDE, 32'h0000_0077, 16'd12, 32'd3, vreq_pkg::VEW_8);
    wait_drain();
    end_test();

    begin_test("channel ordering");
    @(negedge clk_i);
    hold_pop = 1'b1;
    send_request(vreq_pkg::VOP_LOAD_STRIDE, 32'h0000_0500, 16'd3, 32'h40, vreq_pkg::VEW_32);
    send_request(vreq_pkg::VOP_STORE_STRIDE, 32'h0000_0900, 16'd2, 32'd4, vreq_pkg::VEW_32);
    // Store stays parked behind the queued loads
    repeat (30) @(posedge clk_i);
    @(negedge clk_i);
    hold_pop = 1'b0;
    wait_drain();
    end_test();

    repeat (5) @(posedge clk_i);
    $display("%0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (err_cnt == 0)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- vaddrgen_top.f
+incdir+.
vreq_pkg.sv
axi_burst_pkg.sv
sync_fifo.sv
vreq_frontend.sv
burst_engine.sv
vaddrgen_top.sv
tb_vaddrgen_top.sv

//--- vaddrgen_top.sv
`include "vldst_defines.svh"

module vaddrgen_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Vector memory requests
  input  vreq_pkg::vmem_op_e          req_op_i,
  input  logic [`ADDR_WIDTH-1:0]      req_addr_i,
  input  logic [`VL_WIDTH-1:0]        req_vl_i,
  input  logic [`ADDR_WIDTH-1:0]      req_stride_i,
  input  vreq_pkg::vew_e              req_vew_i,
  input  logic                        req_valid_i,
  output logic                        req_ack_o,
  output logic                        req_error_o,
  // AR channel
  output axi_burst_pkg::axi_addr_u    ar_addr_o,
  output logic [`AXI_LEN_WIDTH-1:0]   ar_len_o,
  output logic [`AXI_SIZE_WIDTH-1:0]  ar_size_o,
  output logic                        ar_valid_o,
  input  logic                        ar_ready_i,
  // AW channel
  output axi_burst_pkg::axi_addr_u    aw_addr_o,
  output logic [`AXI_LEN_WIDTH-1:0]   aw_len_o,
  output logic [`AXI_SIZE_WIDTH-1:0]  aw_size_o,
  output logic                        aw_valid_o,
  input  logic                        aw_ready_i,
  // Commands for the load/store units
  output axi_burst_pkg::lsu_cmd_t     cmd_o,
  output logic                        cmd_valid_o,
  input  logic                        cmd_pop_i
);

  // Request buffer
  logic                    req_push, req_full, req_pop, req_empty;
  vreq_pkg::vreq_t         req_wdata, req_rdata;

  // Command queue
  logic                    cmd_push, cmd_full, cmd_empty;
  axi_burst_pkg::lsu_cmd_t cmd_wdata;

  vreq_frontend u_frontend (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_vl_i    (req_vl_i),
    .req_stride_i(req_stride_i),
    .req_vew_i   (req_vew_i),
    .req_valid_i (req_valid_i),
    .req_ack_o   (req_ack_o),
    .req_error_o (req_error_o),
    .fifo_full_i (req_full),
    .fifo_push_o (req_push),
    .fifo_data_o (req_wdata)
  );

  sync_fifo #(
    .depth(`REQ_FIFO_DEPTH),
    .width($bits(vreq_pkg::vreq_t))
  ) u_req_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (req_push),
    .data_i (req_wdata),
    .pop_i  (req_pop),
    .data_o (req_rdata),
    .full_o (req_full),
    .empty_o(req_empty)
  );

  burst_engine u_engine (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_empty_i       (req_empty),
    .req_data_i        (req_rdata),
    .req_pop_o         (req_pop),
    .ar_addr_o         (ar_addr_o),
    .ar_len_o          (ar_len_o),
    .ar_size_o         (ar_size_o),
    .ar_valid_o        (ar_valid_o),
    .ar_ready_i        (ar_ready_i),
    .aw_addr_o         (aw_addr_o),
    .aw_len_o          (aw_len_o),
    .aw_size_o         (aw_size_o),
    .aw_valid_o        (aw_valid_o),
    .aw_ready_i        (aw_ready_i),
    .cmd_full_i        (cmd_full),
    .cmd_empty_i       (cmd_empty),
    // Head kind steers channel ordering
    .cmd_head_is_load_i(cmd_o.is_load),
    .cmd_push_o        (cmd_push),
    .cmd_data_o        (cmd_wdata)
  );

  sync_fifo #(
    .depth(`CMD_FIFO_DEPTH),
    .width($bits(axi_burst_pkg::lsu_cmd_t))
  ) u_cmd_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_push),
    .data_i (cmd_wdata),
    .pop_i  (cmd_pop_i),
    .data_o (cmd_o),
    .full_o (cmd_full),
    .empty_o(cmd_empty)
  );

  assign cmd_valid_o = !cmd_empty;

endmodule

//--- vldst_defines.svh
`ifndef VLDST_DEFINES_SVH
`define VLDST_DEFINES_SVH

////////////////////
// Address side
////////////////////

// Byte address width on the memory bus
`define ADDR_WIDTH 32
// Page offset width, 4 KiB pages
`define PAGE_BITS 12

////////////////////
// Request side
////////////////////

// Element counter width of a vector request
`define VL_WIDTH 16

////////////////////
// Bus beats
////////////////////

// log2 of bus bytes, 64-bit data bus
`define BUS_BYTES_LOG 3
// AXI len and size field widths
`define AXI_LEN_WIDTH 8
`define AXI_SIZE_WIDTH 3
// Longest INCR burst in beats
`define MAX_BURST_BEATS 256

// Queue depths
`define REQ_FIFO_DEPTH 2
`define CMD_FIFO_DEPTH 4

`endif

//--- vreq_frontend.sv
`include "vldst_defines.svh"

module vreq_frontend (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Request port, level valid with ack pulse
  input  vreq_pkg::vmem_op_e     req_op_i,
  input  logic [`ADDR_WIDTH-1:0] req_addr_i,
  input  logic [`VL_WIDTH-1:0]   req_vl_i,
  input  logic [`ADDR_WIDTH-1:0] req_stride_i,
  input  vreq_pkg::vew_e         req_vew_i,
  input  logic                   req_valid_i,
  output logic                   req_ack_o,
  output logic                   req_error_o,
  // Request buffer write side
  input  logic                   fifo_full_i,
  output logic                   fifo_push_o,
  output vreq_pkg::vreq_t        fifo_data_o
);

  // Idle waits for valid, check decides the outcome
  typedef enum logic {
    FE_IDLE,
    FE_CHECK
  } fe_state_e;

  fe_state_e              state_q, state_d;
  vreq_pkg::vreq_t        req_q;
  logic [`ADDR_WIDTH-1:0] align_mask;
  logic                   misaligned;
  logic                   empty_vl;

  ////////////////////
  // Checks
  ////////////////////

  // Low address bits that must be zero for this element width
  assign align_mask = (`ADDR_WIDTH'(1) << req_q.vew) - 1'b1;
  assign misaligned = |(req_q.addr & align_mask);
  // Nothing to move, ack only
  assign empty_vl   = (req_q.vl == '0);

  // Buffer word is the latched request
  assign fifo_data_o = req_q;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d     = state_q;
    req_ack_o   = 1'b0;
    req_error_o = 1'b0;
    fifo_push_o = 1'b0;
    case (state_q)
      FE_IDLE: begin
        if (req_valid_i) state_d = FE_CHECK;
      end
      FE_CHECK: begin
        if (misaligned) begin
          // Error and ack in the same cycle
          req_ack_o   = 1'b1;
          req_error_o = 1'b1;
          state_d     = FE_IDLE;
        end else if (empty_vl) begin
          req_ack_o = 1'b1;
          state_d   = FE_IDLE;
        end else if (!fifo_full_i) begin
          // Ack as soon as the request is buffered
          fifo_push_o = 1'b1;
          req_ack_o   = 1'b1;
          state_d     = FE_IDLE;
        end
        // Buffer full, hold here until space frees up
      end
      default: state_d = FE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the request fields when leaving idle
  always_ff @(posedge clk_i) begin
    if ((state_q == FE_IDLE) && req_valid_i) begin
      req_q <= '{
        op:     req_op_i,
        addr:   req_addr_i,
        vl:     req_vl_i,
        stride: req_stride_i,
        vew:    req_vew_i
      };
    end
  end

endmodule

//--- vreq_pkg.sv
`include "vldst_defines.svh"

package vreq_pkg;

  // Vector memory opcodes
  // Bit 0 marks a store, bit 1 marks a strided access
  typedef enum logic [1:0] {
    VOP_LOAD_UNIT    = 2'b00,
    VOP_STORE_UNIT   = 2'b01,
    VOP_LOAD_STRIDE  = 2'b10,
    VOP_STORE_STRIDE = 2'b11
  } vmem_op_e;

  // Element width, log2 of bytes
  typedef enum logic [1:0] {
    VEW_8  = 2'd0,
    VEW_16 = 2'd1,
    VEW_32 = 2'd2,
    VEW_64 = 2'd3
  } vew_e;

  // One vector memory request as held in the request buffer
  typedef struct packed {
    vmem_op_e               op;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`VL_WIDTH-1:0]   vl;
    // Byte stride, wraps like the address
    logic [`ADDR_WIDTH-1:0] stride;
    vew_e                   vew;
  } vreq_t;

  // Opcode decode helpers
  function automatic logic is_load(vmem_op_e op);
    return !op[0];
  endfunction

  function automatic logic is_strided(vmem_op_e op);
    return op[1];
  endfunction

endpackage
